//--- hdl/oam_ram.sv
`include "obj_cfg.svh"

module oam_ram (
    input  logic               clk,
    input  logic               wr,
    input  logic [7:0]         wr_addr,
    input  logic [7:0]         wr_data,
    input  logic [6:0]         rd_addr,
    output obj_pkg::oam_word_u rd_word
);
    localparam int WORDS = `OAM_ENTRIES * 2;

    // One array per byte lane
    logic [7:0] lo_mem [WORDS];
    logic [7:0] hi_mem [WORDS];

    always_ff @(posedge clk) begin
        if (wr) begin
            if (wr_addr[0]) begin
                hi_mem[wr_addr[7:1]] <= wr_data;
            end else begin
                lo_mem[wr_addr[7:1]] <= wr_data;
            end
        end
    end

    // Word is ready one clock after its address
    always_ff @(posedge clk) begin
        rd_word <= {hi_mem[rd_addr], lo_mem[rd_addr]};
    end

    // Bytes past the last entry have no storage
    wr_in_range: assert property (@(posedge clk)
        wr |-> wr_addr < (`OAM_ENTRIES * 4));

endmodule

//--- hdl/obj_cfg.svh
`ifndef OBJ_CFG_SVH
`define OBJ_CFG_SVH

// Sprite slots per line
`define OBJ_SLOTS 10

// Four bytes per entry, read as two words
`define OAM_ENTRIES 40

// Visible pixels per line
`define LINE_WIDTH 160

// Credits the pixel consumer grants at reset
`define PIX_CREDITS 4

`endif

//--- hdl/obj_fetcher.sv
`include "obj_cfg.svh"

module obj_fetcher (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  line_start,
    input  logic                  scan_done,
    output logic                  busy,
    output logic                  query,
    output logic [7:0]            lx,
    input  logic                  hit,
    input  obj_pkg::sprite_data_t hit_data,
    output logic [11:0]           tile_rd_addr,
    input  logic [7:0]            tile_rd_data,
    output logic                  pix_valid,
    output logic [1:0]            pix_color,
    output logic                  pix_palette,
    output logic                  pix_priority,
    input  logic                  credit_ret,
    output logic                  line_done
);
    import obj_pkg::*;

    localparam int CW = $clog2(`PIX_CREDITS + 1);

    // Fetch sequence
    // The hit cycle itself presents the low address
    localparam logic [1:0] S_RUN  = 2'd0;
    localparam logic [1:0] S_HI   = 2'd1;
    localparam logic [1:0] S_LOAD = 2'd2;

    logic [1:0]    state;
    logic [CW-1:0] credits;
    logic [3:0]    pix_left;
    logic [7:0]    sh_lo;
    logic [7:0]    sh_hi;
    logic [7:0]    lo_buf;
    sprite_data_t  spr;
    logic          drawing;
    logic          empty;
    logic          fetch_go;
    logic          last_pix;

    function automatic logic [7:0] flip8(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

    assign drawing   = busy & scan_done;
    assign empty     = (pix_left == 4'd0);
    assign query     = drawing & (state == S_RUN) & empty;
    assign fetch_go  = query & hit;
    assign pix_valid = drawing & (state == S_RUN) & ~fetch_go & (credits != '0);
    assign last_pix  = pix_valid & (lx == 8'(`LINE_WIDTH - 1));

    // Empty shifter is transparent
    assign pix_color    = empty ? 2'b00 : {sh_hi[7], sh_lo[7]};
    assign pix_palette  = ~empty & spr.attrs.palette;
    assign pix_priority = ~empty & spr.attrs.prio;

    always_comb begin
        if (state == S_HI) begin
            tile_rd_addr = {spr.tile, spr.row, 1'b1};
        end else begin
            tile_rd_addr = {hit_data.tile, hit_data.row, 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy      <= 1'b0;
            line_done <= 1'b0;
            state     <= S_RUN;
            lx        <= '0;
            pix_left  <= '0;
        end else begin
            line_done <= last_pix;
            if (line_start && !busy) begin
                busy <= 1'b1;
            end else if (last_pix) begin
                busy <= 1'b0;
            end
            case (state)
                S_RUN: begin
                    if (fetch_go) begin
                        state <= S_HI;
                    end
                end
                S_HI: state <= S_LOAD;
                default: state <= S_RUN;
            endcase
            if (last_pix) begin
                lx <= '0;
            end else if (pix_valid) begin
                lx <= lx + 8'd1;
            end
            // Leftover pixels of a sprite at the right edge are dropped
            if (last_pix) begin
                pix_left <= '0;
            end else if (state == S_LOAD) begin
                pix_left <= 4'd8;
            end else if (pix_valid && !empty) begin
                pix_left <= pix_left - 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) begin
            spr <= hit_data;
        end
        if (state == S_HI) begin
            lo_buf <= tile_rd_data;
        end
        if (state == S_LOAD) begin
            sh_lo <= spr.attrs.xflip ? flip8(lo_buf) : lo_buf;
            sh_hi <= spr.attrs.xflip ? flip8(tile_rd_data) : tile_rd_data;
        end else if (pix_valid && !empty) begin
            sh_lo <= {sh_lo[6:0], 1'b0};
            sh_hi <= {sh_hi[6:0], 1'b0};
        end
    end

    // Credits come back from the consumer one per cycle
    always_ff @(posedge clk) begin
        if (!rst) begin
            credits <= CW'(`PIX_CREDITS);
        end else if (credit_ret && !pix_valid) begin
            credits <= credits + 1'b1;
        end else if (!credit_ret && pix_valid) begin
            credits <= credits - 1'b1;
        end
    end

    credit_max: assert property (@(posedge clk) disable iff (!rst)
        credits <= CW'(`PIX_CREDITS));

endmodule

//--- hdl/obj_line_top.sv
module obj_line_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        line_start,
    input  logic [7:0]  ly,
    input  logic        cfg_tall,
    input  logic        oam_wr,
    input  logic [7:0]  oam_wr_addr,
    input  logic        tile_wr,
    input  logic [11:0] tile_wr_addr,
    input  logic [7:0]  wr_data,
    output logic        pix_valid,
    output logic [1:0]  pix_color,
    output logic        pix_palette,
    output logic        pix_priority,
    input  logic        credit_ret,
    output logic        busy,
    output logic        line_done
);
    import obj_pkg::*;

    logic [6:0]   oam_rd_addr;
    oam_word_u    oam_rd_word;
    logic [11:0]  tile_rd_addr;
    logic [7:0]   tile_rd_data;
    logic         scan_done;
    logic         query;
    logic [7:0]   lx;
    logic         hit;
    sprite_data_t hit_data;

    oam_ram u_oam (
        .clk     (clk),
        .wr      (oam_wr),
        .wr_addr (oam_wr_addr),
        .wr_data (wr_data),
        .rd_addr (oam_rd_addr),
        .rd_word (oam_rd_word)
    );

    tile_ram u_tile (
        .clk     (clk),
        .wr      (tile_wr),
        .wr_addr (tile_wr_addr),
        .wr_data (wr_data),
        .rd_addr (tile_rd_addr),
        .rd_data (tile_rd_data)
    );

    sprite_chain u_chain (
        .clk         (clk),
        .rst         (rst),
        .line_start  (line_start),
        .ly          (ly),
        .cfg_tall    (cfg_tall),
        .oam_rd_addr (oam_rd_addr),
        .oam_rd_word (oam_rd_word),
        .scan_done   (scan_done),
        .query       (query),
        .lx          (lx),
        .hit         (hit),
        .hit_data    (hit_data)
    );

    // Line state lives in the fetcher
    obj_fetcher u_fetch (
        .clk          (clk),
        .rst          (rst),
        .line_start   (line_start),
        .scan_done    (scan_done),
        .busy         (busy),
        .query        (query),
        .lx           (lx),
        .hit          (hit),
        .hit_data     (hit_data),
        .tile_rd_addr (tile_rd_addr),
        .tile_rd_data (tile_rd_data),
        .pix_valid    (pix_valid),
        .pix_color    (pix_color),
        .pix_palette  (pix_palette),
        .pix_priority (pix_priority),
        .credit_ret   (credit_ret),
        .line_done    (line_done)
    );

endmodule

//--- hdl/obj_pkg.sv
package obj_pkg;

    // What a slot keeps until its X comes up
    typedef struct packed {
        logic [2:0] row;        // pattern row with Y-flip applied
        logic [7:0] tile;
        struct packed {
            logic prio;
            logic yflip;
            logic xflip;
            logic palette;
        } attrs;
    } sprite_data_t;

    // Link between slots, bypass means taken or skipped
    typedef struct packed {
        logic [7:0]   x;
        sprite_data_t data;
        logic         bypass;
    } sprite_bus_t;

    // Even OAM words carry the position and odd words carry tile and attributes
    typedef union packed {
        struct packed {
            logic [7:0] x;
            logic [7:0] y;
        } pos;
        struct packed {
            logic [7:0] attrs;
            logic [7:0] tile;
        } info;
    } oam_word_u;

endpackage

//--- hdl/sprite_chain.sv
`include "obj_cfg.svh"

module sprite_chain (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  line_start,
    input  logic [7:0]            ly,
    input  logic                  cfg_tall,
    output logic [6:0]            oam_rd_addr,
    input  obj_pkg::oam_word_u    oam_rd_word,
    output logic                  scan_done,
    input  logic                  query,
    input  logic [7:0]            lx,
    output logic                  hit,
    output obj_pkg::sprite_data_t hit_data
);
    import obj_pkg::*;

    localparam logic [6:0] LAST_WORD = 7'(`OAM_ENTRIES * 2 - 1);

    logic        scanning;
    logic        word_valid;
    logic        word_odd;
    logic        start;
    logic        slot_rst;
    logic        load;
    oam_word_u   pos_buf;
    logic [7:0]  dy;
    logic [3:0]  row;
    logic        visible;
    sprite_bus_t bus [0:`OBJ_SLOTS];

    assign start    = line_start & ~scanning & ~word_valid;
    assign slot_rst = rst & ~start;
    assign load     = word_valid & word_odd;

    // One OAM word per cycle, data trails the address by one clock
    always_ff @(posedge clk) begin
        if (!rst) begin
            scanning    <= 1'b0;
            word_valid  <= 1'b0;
            word_odd    <= 1'b0;
            scan_done   <= 1'b0;
            oam_rd_addr <= '0;
        end else begin
            word_valid <= scanning;
            word_odd   <= oam_rd_addr[0];
            if (start) begin
                scanning    <= 1'b1;
                scan_done   <= 1'b0;
                oam_rd_addr <= '0;
            end else if (scanning) begin
                if (oam_rd_addr == LAST_WORD) begin
                    scanning <= 1'b0;
                end else begin
                    oam_rd_addr <= oam_rd_addr + 7'd1;
                end
            end
            // Last tile half has arrived
            if (load && !scanning) begin
                scan_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid && !word_odd) begin
            pos_buf <= oam_rd_word;
        end
    end

    // Sprite top sits 16 lines above the screen
    assign dy      = ly - (pos_buf.pos.y - 8'd16);
    assign row     = oam_rd_word.info.attrs[6] ? ~dy[3:0] : dy[3:0];
    assign visible = cfg_tall ? (dy[7:4] == 4'd0) : (dy[7:3] == 5'd0);

    always_comb begin
        bus[0] = '0;
        if (load) begin
            bus[0].x          = pos_buf.pos.x;
            bus[0].data.row   = row[2:0];
            bus[0].data.tile  = oam_rd_word.info.tile;
            bus[0].data.attrs = oam_rd_word.info.attrs[7:4];
            bus[0].bypass     = ~visible;
            if (cfg_tall) begin
                bus[0].data.tile[0] = row[3];
            end
        end else begin
            bus[0].x      = lx;
            bus[0].bypass = ~query;
        end
    end

    for (genvar i = 0; i < `OBJ_SLOTS; i++) begin : g_slot
        sprite_slot slot (
            .clk      (clk),
            .rst      (slot_rst),
            .load     (load),
            .prev_in  (bus[i]),
            .next_out (bus[i + 1])
        );
    end

    assign hit      = query & ~load & bus[`OBJ_SLOTS].bypass;
    assign hit_data = bus[`OBJ_SLOTS].data;

    // Fetcher must not query before the slots are settled
    no_hit_in_scan: assert property (@(posedge clk) disable iff (!rst)
        (scanning || word_valid) |-> !hit);

endmodule

//--- hdl/sprite_slot.sv
module sprite_slot (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  obj_pkg::sprite_bus_t prev_in,
    output obj_pkg::sprite_bus_t next_out
);
    import obj_pkg::*;

    logic         ready;
    logic [7:0]   x;
    sprite_data_t data;
    logic         take;
    logic         chosen;

    // First empty slot claims the entry still on the bus
    assign take = load & ~ready & ~prev_in.bypass;
    // First filled slot with a matching X answers the query
    assign chosen = ~load & ~prev_in.bypass & ready & (x == prev_in.x);

    always_comb begin
        next_out = prev_in;
        if (take) begin
            next_out.bypass = 1'b1;
        end else if (chosen) begin
            next_out.x      = x;
            next_out.data   = data;
            next_out.bypass = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ready <= 1'b0;
        end else if (take) begin
            ready <= 1'b1;
        end else if (chosen) begin
            ready <= 1'b0;  // handed over, slot is free again
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            x    <= prev_in.x;
            data <= prev_in.data;
        end
    end

endmodule

//--- hdl/tile_ram.sv
module tile_ram (
    input  logic        clk,
    input  logic        wr,
    input  logic [11:0] wr_addr,
    input  logic [7:0]  wr_data,
    input  logic [11:0] rd_addr,
    output logic [7:0]  rd_data
);
    // Two bytes per tile row, low bit plane at the even address
    logic [7:0] mem [4096];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- sim.f
+incdir+hdl
+incdir+sim
hdl/obj_pkg.sv
hdl/oam_ram.sv
hdl/tile_ram.sv
hdl/sprite_slot.sv
hdl/sprite_chain.sv
hdl/obj_fetcher.sv
hdl/obj_line_top.sv
sim/tb_obj_line.sv

//--- sim/tb_obj_model.svh
`ifndef TB_OBJ_MODEL_SVH
`define TB_OBJ_MODEL_SVH

// Fibonacci LFSR with taps 16 14 13 11, new bit enters at bit 0
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// Expected line as {priority, palette, color} per pixel, from the memory images
function automatic void build_expected(input logic [7:0] line_y, input logic tall);
    logic [7:0]  spr_x  [`OBJ_SLOTS];
    logic [7:0]  spr_lo [`OBJ_SLOTS];
    logic [7:0]  spr_hi [`OBJ_SLOTS];
    logic [7:0]  spr_at [`OBJ_SLOTS];
    int          count;
    int          left;
    int          cur;
    int          bit_sel;
    logic [7:0]  dy;
    logic [7:0]  attrs;
    logic [7:0]  tile;
    logic [3:0]  row;
    logic [11:0] addr;
    count = 0;
    left  = 0;
    cur   = 0;
    for (int e = 0; e < `OAM_ENTRIES; e++) begin
        // Sprite top sits 16 lines above line 0
        dy    = line_y + 8'd16 - oam_img[4 * e];
        tile  = oam_img[4 * e + 2];
        attrs = oam_img[4 * e + 3];
        if (count < `OBJ_SLOTS && dy < (tall ? 8'd16 : 8'd8)) begin
            row = attrs[6] ? (tall ? 4'd15 : 4'd7) - dy[3:0] : dy[3:0];
            if (tall) begin
                tile[0] = row[3];
            end
            addr          = {tile, row[2:0], 1'b0};
            spr_x[count]  = oam_img[4 * e + 1];
            spr_lo[count] = tile_img[addr];
            spr_hi[count] = tile_img[addr | 12'd1];
            spr_at[count] = attrs;
            count++;
        end
    end
    for (int lx = 0; lx < `LINE_WIDTH; lx++) begin
        // Only an idle shifter looks for a new sprite, earliest entry wins
        if (left == 0) begin
            for (int s = count - 1; s >= 0; s--) begin
                if (spr_x[s] == 8'(lx)) begin
                    cur  = s;
                    left = 8;
                end
            end
        end
        if (left > 0) begin
            bit_sel     = spr_at[cur][5] ? 8 - left : left - 1;
            exp_pix[lx] = {spr_at[cur][7], spr_at[cur][4],
                           spr_hi[cur][bit_sel], spr_lo[cur][bit_sel]};
            left--;
        end else begin
            exp_pix[lx] = 4'h0;
        end
    end
endfunction

`endif

//--- sim/tb_obj_line.sv
`include "obj_cfg.svh"

module tb_obj_line;

    // Scan, full line, one fetch per slot, and room for back-pressure
    localparam int LINE_CYCLES = 2 * `OAM_ENTRIES + 1 + `LINE_WIDTH + 3 * `OBJ_SLOTS
                                 + `LINE_WIDTH;
    localparam int FILL_CYCLES = 2 * 4096 + 8 * 4 * `OAM_ENTRIES + 16;
    localparam int MAX_CYCLES  = 8 * (LINE_CYCLES + 8) + FILL_CYCLES;

    logic        clk = 1'b0;
    logic        rst;
    logic        line_start;
    logic [7:0]  ly;
    logic        cfg_tall;
    logic        oam_wr;
    logic [7:0]  oam_wr_addr;
    logic        tile_wr;
    logic [11:0] tile_wr_addr;
    logic [7:0]  wr_data;
    logic        credit_ret = 1'b0;
    logic        pix_valid;
    logic [1:0]  pix_color;
    logic        pix_palette;
    logic        pix_priority;
    logic        busy;
    logic        line_done;

    logic [7:0]  oam_img  [4 * `OAM_ENTRIES];
    logic [7:0]  tile_img [4096];
    logic [3:0]  exp_pix  [`LINE_WIDTH];
    logic [15:0] lfsr = 16'd87;
    logic [3:0]  got;
    logic        slow_credits = 1'b0;
    int          pix_idx = 0;
    int          pix_total = 0;
    int          returned = 0;
    int          lines_done = 0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    int          cycles = 0;

    `include "tb_obj_model.svh"

    obj_line_top uut (
        .clk          (clk),
        .rst          (rst),
        .line_start   (line_start),
        .ly           (ly),
        .cfg_tall     (cfg_tall),
        .oam_wr       (oam_wr),
        .oam_wr_addr  (oam_wr_addr),
        .tile_wr      (tile_wr),
        .tile_wr_addr (tile_wr_addr),
        .wr_data      (wr_data),
        .pix_valid    (pix_valid),
        .pix_color    (pix_color),
        .pix_palette  (pix_palette),
        .pix_priority (pix_priority),
        .credit_ret   (credit_ret),
        .busy         (busy),
        .line_done    (line_done)
    );

    always #5 clk = ~clk;

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic write_tile(input logic [11:0] addr, input logic [7:0] data);
        tile_wr        = 1'b1;
        tile_wr_addr   = addr;
        wr_data        = data;
        tile_img[addr] = data;
        @(posedge clk);
        #1;
        tile_wr = 1'b0;
    endtask

    task automatic load_oam();
        for (int a = 0; a < 4 * `OAM_ENTRIES; a++) begin
            oam_wr      = 1'b1;
            oam_wr_addr = 8'(a);
            wr_data     = oam_img[a];
            @(posedge clk);
            #1;
        end
        oam_wr = 1'b0;
    endtask

    // Y of 0 keeps an entry off every line
    task automatic clear_oam();
        for (int a = 0; a < 4 * `OAM_ENTRIES; a++) begin
            oam_img[a] = 8'h00;
        end
    endtask

    task automatic place_sprite(input int e, input logic [7:0] y, input logic [7:0] x,
                                input logic [7:0] tile, input logic [7:0] attrs);
        oam_img[4 * e]     = y;
        oam_img[4 * e + 1] = x;
        oam_img[4 * e + 2] = tile;
        oam_img[4 * e + 3] = attrs;
    endtask

    // Six hidden entries ahead of fourteen visible ones for line 80
    task automatic place_crowd();
        clear_oam();
        for (int j = 0; j < 6; j++) begin
            place_sprite(j, (j % 2) ? 8'd97 : 8'd88, 8'(147 - 11 * j), 8'(j), 8'h10);
        end
        for (int k = 0; k < 14; k++) begin
            place_sprite(6 + k, 8'(96 - k % 8), 8'(147 - 11 * k), 8'(16 + k), 8'(k << 4));
        end
    endtask

    task automatic run_line(input logic [7:0] line_y, input logic tall);
        int seen;
        build_expected(line_y, tall);
        ly       = line_y;
        cfg_tall = tall;
        seen     = lines_done;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        line_start = 1'b1;
        @(posedge clk);
        #1;
        line_start = 1'b0;
        assert (busy) else begin
            $display("Busy did not rise after the line start at time %0t", $time);
            errors++;
        end
        while (lines_done == seen) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("test %0d %s: ok", num, name);
            passed++;
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_mark);
            failed++;
        end
    endtask

    // Consumer hands back one credit per cycle while it owes any
    always @(posedge clk) begin
        #1;
        credit_ret = 1'b0;
        if (pix_total > returned) begin
            if (!slow_credits || take_bits(2) != 8'd0) begin
                credit_ret = 1'b1;
                returned++;
            end
        end
    end

    always @(negedge clk) begin
        if (pix_valid) begin
            assert (pix_idx < `LINE_WIDTH) else begin
                $display("More than %0d pixels arrived in one line", `LINE_WIDTH);
                errors++;
            end
            if (pix_idx < `LINE_WIDTH) begin
                got = {pix_priority, pix_palette, pix_color};
                assert (got === exp_pix[pix_idx]) else begin
                    $display("FAILED at %0t: pixel %0d is %h, expected %h",
                             $time, pix_idx, got, exp_pix[pix_idx]);
                    errors++;
                end
            end
            pix_idx++;
            pix_total++;
            assert (pix_total - returned + int'(credit_ret) <= `PIX_CREDITS) else begin
                $display("A pixel was sent without a credit at time %0t", $time);
                errors++;
            end
        end
        if (line_done) begin
            assert (pix_idx == `LINE_WIDTH) else begin
                $display("Line ended after %0d pixels instead of %0d", pix_idx, `LINE_WIDTH);
                errors++;
            end
            assert (!busy) else begin
                $display("Busy stayed high when the line ended at time %0t", $time);
                errors++;
            end
            pix_idx = 0;
            lines_done++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int err_mark;
        rst          = 1'b0;
        line_start   = 1'b0;
        ly           = 8'd0;
        cfg_tall     = 1'b0;
        oam_wr       = 1'b0;
        oam_wr_addr  = 8'd0;
        tile_wr      = 1'b0;
        tile_wr_addr = 12'd0;
        wr_data      = 8'd0;
        repeat (2) @(posedge clk);
        #1;
        assert (!busy && !line_done && !pix_valid) else begin
            $display("Busy, line done or pixel valid was high after reset");
            errors++;
        end
        rst = 1'b1;
        for (int a = 0; a < 4096; a++) begin
            write_tile(12'(a), 8'(a) ^ 8'(a >> 4));
        end

        err_mark = errors;
        clear_oam();
        place_sprite(0, 8'd53, 8'd20, 8'd5, 8'h00);
        write_tile(12'd86, 8'b1010_0110);
        write_tile(12'd87, 8'b1100_1010);
        load_oam();
        run_line(8'd40, 1'b0);
        report_test(1, "single sprite", err_mark);

        // Entry 3 is one row too low for short sprites only
        err_mark = errors;
        clear_oam();
        place_sprite(0, 8'd74, 8'd10, 8'h21, 8'h40);
        place_sprite(1, 8'd70, 8'd40, 8'h33, 8'h30);
        place_sprite(2, 8'd71, 8'd70, 8'h44, 8'he0);
        place_sprite(3, 8'd68, 8'd100, 8'h50, 8'h00);
        load_oam();
        run_line(8'd60, 1'b0);
        run_line(8'd60, 1'b1);
        report_test(2, "flips and tall mode", err_mark);

        err_mark = errors;
        place_crowd();
        load_oam();
        run_line(8'd80, 1'b0);
        report_test(3, "slot limit", err_mark);

        // Equal X, X inside a busy shifter, X right after it, clipped at the edge
        err_mark = errors;
        clear_oam();
        place_sprite(0, 8'd115, 8'd30, 8'h60, 8'h00);
        place_sprite(1, 8'd114, 8'd30, 8'h61, 8'h10);
        place_sprite(2, 8'd113, 8'd50, 8'h62, 8'h20);
        place_sprite(3, 8'd112, 8'd53, 8'h63, 8'h80);
        place_sprite(4, 8'd111, 8'd58, 8'h64, 8'h40);
        place_sprite(5, 8'd110, 8'd156, 8'h65, 8'h30);
        load_oam();
        run_line(8'd100, 1'b0);
        report_test(4, "overlap and drop", err_mark);

        err_mark = errors;
        slow_credits = 1'b1;
        place_crowd();
        load_oam();
        run_line(8'd81, 1'b0);
        slow_credits = 1'b0;
        report_test(5, "random credit return", err_mark);

        err_mark = errors;
        for (int a = 0; a < 4096; a++) begin
            write_tile(12'(a), take_bits(8));
        end
        for (int e = 0; e < `OAM_ENTRIES; e++) begin
            place_sprite(e, 8'd80 + take_bits(5), take_bits(8), take_bits(8), take_bits(8));
        end
        load_oam();
        run_line(8'd70, 1'b0);
        run_line(8'd78, 1'b1);
        report_test(6, "random two lines", err_mark);

        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
